//--- alu_tests.txt
// Columns in hex: opcode a b expected_result expected_flags
// Flags bits from 3 down to 0 are v c s z
01 7f 01 80 a  // Add signed overflow
01 ff 01 00 5  // Add wraps to zero with carry
01 12 34 46 0
01 80 80 00 d  // Add both negative
02 05 05 00 5  // Sub equal, no borrow
02 03 05 fe 2  // Sub with borrow
02 80 01 7f c  // Sub signed overflow
02 7f ff 80 a
03 10 10 00 d  // Mul high byte only
03 03 04 0c 0
03 07 09 3f 0
03 ff 02 fe 6  // Mul carry, -1 * 2 in range
03 0b 0c 84 a  // Mul signed out of range
04 c8 07 1c 0  // 200 / 7
05 c8 07 04 0  // 200 mod 7
04 2a 00 00 5  // Divide by zero
05 2a 00 00 5  // Modulo by zero
04 05 0a 00 1
06 f0 3c 30 0
07 80 01 81 2
08 aa aa 00 1
09 0f 55 f0 2  // Not ignores b
0a 0f f0 00 1
0b ff 0f f0 2
0c 3c 0f cc 2
00 12 34 00 0  // Unknown opcodes
0d ff ff 00 0
ff 01 01 00 0
01 01 01 02 0
02 01 02 ff 2

//--- project.f
alu_types_pkg.sv
isa_pkg.sv
issue_register.sv
arith_unit.sv
divide_unit.sv
logic_unit.sv
writeback_stage.sv
alu_core.sv
alu_checker.sv
alu_assertions.sv
tb_alu_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert --top-module tb_alu_core -f project.f > build.log 2>&1 ||
    { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_alu_core > sim.log 2>&1 ||
    { echo "Simulation exited with an error, see sim.log"; exit 1; }
grep -q -F '*** FAILED ***' sim.log &&
    { echo "Simulation reported failure, see sim.log"; exit 1; }
grep -q -F '*** PASSED ***' sim.log ||
    { echo "No pass message in sim.log"; exit 1; }
echo "Simulation passed"

//--- tb_alu_core.sv
`timescale 1ns/10ps

module tb_alu_core;

    localparam int MAX_TESTS    = 64;
    localparam int WORDS        = 5;                // Columns per test line
    localparam int MEM_DEPTH    = MAX_TESTS * WORDS;
    localparam int RESET_CYCLES = 3;
    localparam int SLACK_CYCLES = 20;

    // One line of the test file
    typedef struct packed {
        isa_pkg::opcode_t          opcode;
        alu_types_pkg::data_t      a;
        alu_types_pkg::data_t      b;
        alu_types_pkg::data_t      exp_result;
        alu_types_pkg::alu_flags_t exp_flags;
    } test_vec_t;

    logic                      clk;
    logic                      reset;
    isa_pkg::opcode_t          opcode;
    alu_types_pkg::data_t      operand_a;
    alu_types_pkg::data_t      operand_b;
    alu_types_pkg::data_t      result;
    alu_types_pkg::alu_flags_t flags;

    logic                      exp_valid;           // Expectation handed to the checker
    int                        exp_index;
    alu_types_pkg::data_t      exp_result;
    alu_types_pkg::alu_flags_t exp_flags;

    logic [8:0] test_mem [0:MEM_DEPTH-1];           // Bit 8 set means not loaded
    int         num_tests;
    int         cycle_count = 0;
    int         cycle_limit = MAX_TESTS + RESET_CYCLES + SLACK_CYCLES;
    int         load_errors = 0;
    int         timeout_errors = 0;
    int         checks;
    int         result_errors;
    int         flag_errors;

    alu_core i_dut (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (result),
        .flags     (flags)
    );

    alu_checker i_checker (
        .clk           (clk),
        .reset         (reset),
        .exp_valid     (exp_valid),
        .exp_index     (exp_index),
        .exp_result    (exp_result),
        .exp_flags     (exp_flags),
        .result        (result),
        .flags         (flags),
        .checks        (checks),
        .result_errors (result_errors),
        .flag_errors   (flag_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    // Fill, read the file, count complete lines
    task automatic load_tests();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            test_mem[i] = {1'b1, 8'(i) ^ 8'(i >> 8)};
        end
        $readmemh("alu_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && !test_mem[num_tests * WORDS][8]) begin
            for (int w = 1; w < WORDS; w++) begin
                if (test_mem[num_tests * WORDS + w][8]) begin
                    $display("Test line %0d in alu_tests.txt is missing a column", num_tests);
                    load_errors = load_errors + 1;
                end
            end
            num_tests = num_tests + 1;
        end
        if (num_tests == 0) begin
            $display("No tests could be read from alu_tests.txt");
            load_errors = load_errors + 1;
        end
    endtask

    function automatic test_vec_t fetch_test(int idx);
        test_vec_t t;
        t.opcode     = test_mem[idx * WORDS][7:0];
        t.a          = test_mem[idx * WORDS + 1][7:0];
        t.b          = test_mem[idx * WORDS + 2][7:0];
        t.exp_result = test_mem[idx * WORDS + 3][7:0];
        t.exp_flags  = test_mem[idx * WORDS + 4][3:0];  // v c s z
        return t;
    endfunction

    task automatic drive_test(int idx);
        test_vec_t t;
        t          = fetch_test(idx);
        opcode     = t.opcode;
        operand_a  = t.a;
        operand_b  = t.b;
        exp_valid  = 1'b1;
        exp_index  = idx;
        exp_result = t.exp_result;
        exp_flags  = t.exp_flags;
    endtask

    function automatic int error_total();
        return result_errors + flag_errors + timeout_errors + load_errors;
    endfunction

    task automatic print_summary();
        $display("Checked %0d of %0d tests, errors %0d result %0d flags %0d timeout %0d load",
                 checks, num_tests, result_errors, flag_errors, timeout_errors, load_errors);
    endtask

    // Run limit from the test count
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with only %0d of %0d tests checked",
                     cycle_count, checks, num_tests);
            timeout_errors = timeout_errors + 1;
            print_summary();
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        opcode     = '0;
        operand_a  = '0;
        operand_b  = '0;
        exp_valid  = 1'b0;
        exp_index  = 0;
        exp_result = '0;
        exp_flags  = '0;
        load_tests();
        cycle_limit = num_tests + RESET_CYCLES + SLACK_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            @(posedge clk);
            #1 drive_test(i);                       // One test per cycle with no gaps
        end
        @(posedge clk);
        #1;
        opcode    = '0;                             // Idle op after the last test
        exp_valid = 1'b0;
        while (checks < num_tests) @(posedge clk);
        repeat (2) @(posedge clk);
        print_summary();
        if (error_total() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- alu_assertions.sv
`timescale 1ns/10ps

module alu_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      op_valid,      // Writeback saw a known op
    input alu_types_pkg::data_t      result,
    input alu_types_pkg::alu_flags_t flags
);

    // Registered outputs stay clear under reset
    a_reset_clear: assert property (@(posedge clk) reset |-> (result == '0 && flags == '0))
        else $error("result or flags not clear while reset is held");

    // Z only ever seen with a zero result
    a_zero_needs_zero: assert property (@(posedge clk) disable iff (reset)
        flags.z |-> (result == '0))
        else $error("zero flag set with a nonzero result");

    // Zero result of a real op always raises Z
    a_zero_on_zero: assert property (@(posedge clk) disable iff (reset)
        (result == '0 && $past(op_valid)) |-> flags.z)
        else $error("zero result of a known op without the zero flag");

    // S mirrors the result MSB
    a_sign_msb: assert property (@(posedge clk) disable iff (reset)
        flags.s == result[alu_types_pkg::SIGN_BIT])
        else $error("sign flag differs from the result MSB");

endmodule

bind writeback_stage alu_assertions i_alu_assertions (
    .clk      (clk),
    .reset    (reset),
    .op_valid (op_valid),
    .result   (result),
    .flags    (flags)
);

//--- alu_checker.sv
`timescale 1ns/10ps

module alu_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      exp_valid,    // Test driven this cycle
    input  int                        exp_index,
    input  alu_types_pkg::data_t      exp_result,
    input  alu_types_pkg::alu_flags_t exp_flags,
    input  alu_types_pkg::data_t      result,       // DUT outputs
    input  alu_types_pkg::alu_flags_t flags,
    output int                        checks,
    output int                        result_errors,
    output int                        flag_errors
);

    // One in-flight expectation
    typedef struct packed {
        logic                      valid;
        int                        index;           // Line number in the test file
        alu_types_pkg::data_t      result;
        alu_types_pkg::alu_flags_t flags;
    } expect_t;

    expect_t stage1;                                // Lines up with the issue register
    expect_t stage2;                                // Lines up with the writeback register

    initial begin
        checks        = 0;
        result_errors = 0;
        flag_errors   = 0;
    end

    // Two-cycle delay matching the DUT pipeline
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            stage1 <= '0;
            stage2 <= '0;
        end else begin
            stage1.valid  <= exp_valid;
            stage1.index  <= exp_index;
            stage1.result <= exp_result;
            stage1.flags  <= exp_flags;
            stage2        <= stage1;
        end
    end

    // Compare mid-cycle, outputs settled since the rising edge
    always @(negedge clk) begin
        if (!reset && stage2.valid) begin
            checks = checks + 1;
            if (result !== stage2.result) begin
                result_errors = result_errors + 1;
                $display("error: result test %0d expected 0x%02h got 0x%02h",
                         stage2.index, stage2.result, result);
            end
            if (flags !== stage2.flags) begin
                flag_errors = flag_errors + 1;
                $display("error: flags test %0d expected 0x%01h got 0x%01h",
                         stage2.index, stage2.flags, flags);
            end
        end
    end

endmodule

//--- alu_core.sv
`timescale 1ns/10ps

module alu_core (
    input  logic                      clk,
    input  logic                      reset,
    input  isa_pkg::opcode_t          opcode,
    input  alu_types_pkg::data_t      operand_a,
    input  alu_types_pkg::data_t      operand_b,
    output alu_types_pkg::data_t      result,
    output alu_types_pkg::alu_flags_t flags
);

    isa_pkg::issue_t          issue;                // Issue stage to units and writeback
    alu_types_pkg::unit_out_t arith_out;
    alu_types_pkg::unit_out_t div_out;
    alu_types_pkg::unit_out_t logic_out;

    issue_register i_issue (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .issue     (issue)
    );

    arith_unit i_arith (
        .issue     (issue),
        .arith_out (arith_out)
    );

    divide_unit i_divide (
        .issue   (issue),
        .div_out (div_out)
    );

    logic_unit i_logic (
        .issue     (issue),
        .logic_out (logic_out)
    );

    writeback_stage i_writeback (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .arith_out (arith_out),
        .div_out   (div_out),
        .logic_out (logic_out),
        .result    (result),
        .flags     (flags)
    );

endmodule

//--- writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  isa_pkg::issue_t          issue,
    input  alu_types_pkg::unit_out_t arith_out,
    input  alu_types_pkg::unit_out_t div_out,
    input  alu_types_pkg::unit_out_t logic_out,
    output alu_types_pkg::data_t     result,
    output alu_types_pkg::alu_flags_t flags
);

    alu_types_pkg::unit_out_t   sel;                // Output of the active unit
    alu_types_pkg::alu_flags_t  flags_next;
    logic                       op_valid;           // Low for OP_NONE

    // Unit select by op family
    always_comb begin
        op_valid = 1'b1;
        case (issue.op)
            isa_pkg::OP_ADD,
            isa_pkg::OP_SUB,
            isa_pkg::OP_MUL:  sel = arith_out;
            isa_pkg::OP_DIV,
            isa_pkg::OP_MOD:  sel = div_out;
            isa_pkg::OP_AND,
            isa_pkg::OP_OR,
            isa_pkg::OP_XOR,
            isa_pkg::OP_NOT,
            isa_pkg::OP_NOR,
            isa_pkg::OP_NAND,
            isa_pkg::OP_XNOR: sel = logic_out;
            default: begin
                sel      = '0;                      // Unknown op gives zeros
                op_valid = 1'b0;
            end
        endcase
    end

    // Zero and sign from the result, the rest from the unit
    always_comb begin
        flags_next.z = op_valid && (sel.result == '0);  // No Z on idle cycles
        flags_next.s = sel.result[alu_types_pkg::SIGN_BIT];
        flags_next.c = sel.carry;
        flags_next.v = sel.overflow;
    end

    // Result and flags leave together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= sel.result;
            flags  <= flags_next;
        end
    end

endmodule

//--- logic_unit.sv
`timescale 1ns/10ps

module logic_unit (
    input  isa_pkg::issue_t         issue,
    output alu_types_pkg::unit_out_t logic_out
);

    alu_types_pkg::data_t logic_res;                // Bitwise result

    always_comb begin
        case (issue.op)
            isa_pkg::OP_AND:  logic_res = issue.a & issue.b;
            isa_pkg::OP_OR:   logic_res = issue.a | issue.b;
            isa_pkg::OP_XOR:  logic_res = issue.a ^ issue.b;
            isa_pkg::OP_NOT:  logic_res = ~issue.a;          // Operand b ignored
            isa_pkg::OP_NOR:  logic_res = ~(issue.a | issue.b);
            isa_pkg::OP_NAND: logic_res = ~(issue.a & issue.b);
            isa_pkg::OP_XNOR: logic_res = ~(issue.a ^ issue.b);
            default:          logic_res = '0;                // Not a logic op
        endcase
    end

    // No carry or overflow out of bitwise ops
    always_comb begin
        logic_out.result   = logic_res;
        logic_out.carry    = 1'b0;
        logic_out.overflow = 1'b0;
    end

endmodule

//--- divide_unit.sv
`timescale 1ns/10ps

module divide_unit (
    input  isa_pkg::issue_t         issue,
    output alu_types_pkg::unit_out_t div_out
);

    logic [alu_types_pkg::DATA_WIDTH:0] rem;        // Partial remainder, one guard bit
    logic [alu_types_pkg::DATA_WIDTH:0] trial;      // Remainder minus divisor
    alu_types_pkg::data_t               quo;        // Dividend shifting out, quotient in
    logic                               div_zero;

    assign div_zero = (issue.b == '0);

    // Restoring shift-subtract, one quotient bit per step
    always_comb begin
        rem   = '0;
        trial = '0;
        quo   = issue.a;
        for (int step = 0; step < alu_types_pkg::DATA_WIDTH; step++) begin
            rem   = {rem[alu_types_pkg::DATA_WIDTH-1:0], quo[alu_types_pkg::SIGN_BIT]};
            quo   = {quo[alu_types_pkg::DATA_WIDTH-2:0], 1'b0};
            trial = rem - {1'b0, issue.b};
            if (!trial[alu_types_pkg::DATA_WIDTH]) begin  // No borrow so keep it
                rem    = trial;
                quo[0] = 1'b1;
            end
        end
    end

    // Result select and divide by zero report
    always_comb begin
        div_out = '0;                               // Overflow never set here
        case (issue.op)
            isa_pkg::OP_DIV: begin
                div_out.result = div_zero ? '0 : quo;
                div_out.carry  = div_zero;          // Flags the bad divisor
            end
            isa_pkg::OP_MOD: begin
                div_out.result = div_zero ? '0 : rem[alu_types_pkg::SIGN_BIT:0];
                div_out.carry  = div_zero;
            end
            default: begin
                div_out = '0;
            end
        endcase
    end

endmodule

//--- arith_unit.sv
`timescale 1ns/10ps

module arith_unit (
    input  isa_pkg::issue_t         issue,
    output alu_types_pkg::unit_out_t arith_out
);

    logic [alu_types_pkg::DATA_WIDTH:0]          add_full;  // Sum with carry out on top
    logic [alu_types_pkg::DATA_WIDTH:0]          sub_full;  // Difference with borrow on top
    alu_types_pkg::wide_t                        product;   // Unsigned full product
    logic signed [alu_types_pkg::WIDE_WIDTH-1:0] sproduct;  // Signed full product
    logic                                        a_msb;
    logic                                        b_msb;

    assign a_msb = issue.a[alu_types_pkg::SIGN_BIT];
    assign b_msb = issue.b[alu_types_pkg::SIGN_BIT];

    // All three datapaths evaluated in parallel
    always_comb begin
        add_full = {1'b0, issue.a} + {1'b0, issue.b};
        sub_full = {1'b0, issue.a} - {1'b0, issue.b};
        product  = alu_types_pkg::wide_t'(issue.a) * alu_types_pkg::wide_t'(issue.b);
        sproduct = $signed({{alu_types_pkg::DATA_WIDTH{a_msb}}, issue.a})
                 * $signed({{alu_types_pkg::DATA_WIDTH{b_msb}}, issue.b});  // Sign extended
    end

    // Pick the requested one and form carry and overflow
    always_comb begin
        arith_out = '0;                             // Idle for non arithmetic ops
        case (issue.op)
            isa_pkg::OP_ADD: begin
                arith_out.result   = add_full[alu_types_pkg::SIGN_BIT:0];
                arith_out.carry    = add_full[alu_types_pkg::DATA_WIDTH];  // Ninth bit
                arith_out.overflow = (a_msb == b_msb)
                                  && (add_full[alu_types_pkg::SIGN_BIT] != a_msb);
            end
            isa_pkg::OP_SUB: begin
                arith_out.result   = sub_full[alu_types_pkg::SIGN_BIT:0];
                arith_out.carry    = !sub_full[alu_types_pkg::DATA_WIDTH];  // Set when a >= b
                arith_out.overflow = (a_msb != b_msb)
                                  && (sub_full[alu_types_pkg::SIGN_BIT] != a_msb);
            end
            isa_pkg::OP_MUL: begin
                arith_out.result   = product[alu_types_pkg::SIGN_BIT:0];   // Low byte only
                arith_out.carry    = |product[alu_types_pkg::WIDE_WIDTH-1:
                                              alu_types_pkg::DATA_WIDTH];
                arith_out.overflow = (sproduct > 127) || (sproduct < -128); // Outside int8
            end
            default: begin
                arith_out = '0;
            end
        endcase
    end

endmodule

//--- issue_register.sv
`timescale 1ns/10ps

module issue_register (
    input  logic                 clk,
    input  logic                 reset,
    input  isa_pkg::opcode_t     opcode,
    input  alu_types_pkg::data_t operand_a,
    input  alu_types_pkg::data_t operand_b,
    output isa_pkg::issue_t      issue
);

    isa_pkg::alu_op_t op_dec;                       // Decoded op for the current byte

    // Opcode byte to operation
    always_comb begin
        case (opcode)
            isa_pkg::OPC_ADD:  op_dec = isa_pkg::OP_ADD;
            isa_pkg::OPC_SUB:  op_dec = isa_pkg::OP_SUB;
            isa_pkg::OPC_MUL:  op_dec = isa_pkg::OP_MUL;
            isa_pkg::OPC_DIV:  op_dec = isa_pkg::OP_DIV;
            isa_pkg::OPC_MOD:  op_dec = isa_pkg::OP_MOD;
            isa_pkg::OPC_AND:  op_dec = isa_pkg::OP_AND;
            isa_pkg::OPC_OR:   op_dec = isa_pkg::OP_OR;
            isa_pkg::OPC_XOR:  op_dec = isa_pkg::OP_XOR;
            isa_pkg::OPC_NOT:  op_dec = isa_pkg::OP_NOT;
            isa_pkg::OPC_NOR:  op_dec = isa_pkg::OP_NOR;
            isa_pkg::OPC_NAND: op_dec = isa_pkg::OP_NAND;
            isa_pkg::OPC_XNOR: op_dec = isa_pkg::OP_XNOR;
            default:           op_dec = isa_pkg::OP_NONE;   // Unknown byte does nothing
        endcase
    end

    // Issue stage register, sampled every cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue.op <= isa_pkg::OP_NONE;
            issue.a  <= '0;
            issue.b  <= '0;
        end else begin
            issue.op <= op_dec;
            issue.a  <= operand_a;
            issue.b  <= operand_b;
        end
    end

endmodule

//--- isa_pkg.sv
package isa_pkg;

    // Raw opcode byte as seen on the core input
    typedef logic [7:0] opcode_t;

    localparam opcode_t OPC_ADD  = 8'h01;
    localparam opcode_t OPC_SUB  = 8'h02;
    localparam opcode_t OPC_MUL  = 8'h03;
    localparam opcode_t OPC_DIV  = 8'h04;
    localparam opcode_t OPC_MOD  = 8'h05;
    localparam opcode_t OPC_AND  = 8'h06;
    localparam opcode_t OPC_OR   = 8'h07;
    localparam opcode_t OPC_XOR  = 8'h08;
    localparam opcode_t OPC_NOT  = 8'h09;
    localparam opcode_t OPC_NOR  = 8'h0A;
    localparam opcode_t OPC_NAND = 8'h0B;
    localparam opcode_t OPC_XNOR = 8'h0C;

    // Decoded operation, OP_NONE for anything unknown
    typedef enum logic [3:0] {
        OP_NONE, OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD, OP_AND,
        OP_OR, OP_XOR, OP_NOT, OP_NOR, OP_NAND, OP_XNOR
    } alu_op_t;

    // Registered instruction handed to the execution units
    typedef struct packed {
        alu_op_t              op;                   // Decoded operation
        alu_types_pkg::data_t a;                    // First operand
        alu_types_pkg::data_t b;                    // Second operand
    } issue_t;

endpackage

//--- alu_types_pkg.sv
package alu_types_pkg;

    localparam int DATA_WIDTH = 8;                  // Operand and result width
    localparam int WIDE_WIDTH = 2 * DATA_WIDTH;     // Full product width
    localparam int SIGN_BIT   = DATA_WIDTH - 1;     // Two's complement sign position

    // One operand or result byte
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Unsigned product before truncation
    typedef logic [WIDE_WIDTH-1:0] wide_t;

    // Status flags, MSB first, so z lands in bit 0 of the hex value
    typedef struct packed {
        logic v;                                    // Signed overflow
        logic c;                                    // Carry, no borrow, or divide by zero
        logic s;                                    // Result MSB
        logic z;                                    // Result is zero
    } alu_flags_t;

    // Common return bundle of every execution unit
    typedef struct packed {
        data_t result;                              // Unit result byte
        logic  carry;                               // Unit carry flag
        logic  overflow;                            // Unit overflow flag
    } unit_out_t;

endpackage
